//--- hw/aesPkg.sv
`default_nettype none

package aesPkg;

	typedef logic [31:0] aesWordT;
	// Word 0 is the most significant word of the block
	typedef aesWordT [0:3] aesBlockT;
	typedef logic [3:0] roundIdxT;
	typedef logic [7:0] apbAddrT;

	localparam roundIdxT NumRounds = 4'd10;

	// Register map
	localparam apbAddrT RegCtrl = 8'h00;
	localparam apbAddrT RegKey0 = 8'h08;
	localparam apbAddrT RegPlain0 = 8'h18;
	localparam apbAddrT RegCipher0 = 8'h28;
	localparam int CtrlGoBit = 0;
	localparam int CtrlDoneBit = 31;
	localparam aesWordT UnmappedRead = 32'h00000f0f;

	localparam logic [7:0] sBox [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	function automatic aesWordT rotWord(aesWordT w);
		return {w[23:0], w[31:24]};
	endfunction

	function automatic aesWordT subWord(aesWordT w);
		return {sBox[w[31:24]], sBox[w[23:16]], sBox[w[15:8]], sBox[w[7:0]]};
	endfunction

	// Multiply by x in GF(2^8), polynomial 0x11b
	function automatic logic [7:0] xtime(logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] nextRcon(logic [7:0] rc);
		return xtime(rc);
	endfunction

	// Row r of column c comes from column c + r
	function automatic aesBlockT subShiftRows(aesBlockT s);
		aesBlockT r;
		for (int c = 0; c < 4; c++) begin
			for (int b = 0; b < 4; b++) begin
				r[c][31 - 8 * b -: 8] = sBox[s[(c + b) % 4][31 - 8 * b -: 8]];
			end
		end
		return r;
	endfunction

	function automatic aesWordT mixWord(aesWordT w);
		logic [7:0] a0, a1, a2, a3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	function automatic aesBlockT mixColumns(aesBlockT s);
		aesBlockT r;
		for (int c = 0; c < 4; c++) begin
			r[c] = mixWord(s[c]);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- hw/aesJobIf.sv
`default_nettype none

interface aesJobIf
	import aesPkg::*;
();

	logic start;
	aesBlockT key;
	aesBlockT plainBlock;
	logic resultValid;
	aesBlockT cipherBlock;

	modport bank (
		output start, key, plainBlock,
		input resultValid, cipherBlock
	);

	modport sched (
		input start, key, plainBlock
	);

	modport core (
		output resultValid, cipherBlock
	);

endinterface

`default_nettype wire

//--- hw/aesRoundKeyIf.sv
`default_nettype none

interface aesRoundKeyIf
	import aesPkg::*;
();

	logic keyValid;
	roundIdxT roundIdx;
	aesBlockT roundKey;
	// Only meaningful while roundIdx is 0
	aesBlockT plainBlock;

	modport sched (
		output keyValid, roundIdx, roundKey, plainBlock
	);

	modport core (
		input keyValid, roundIdx, roundKey, plainBlock
	);

endinterface

`default_nettype wire

//--- hw/aesRegBank.sv
`default_nettype none

module aesRegBank
	import aesPkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input aesWordT pwdata,
	output aesWordT prdata,
	output logic pready,
	output logic pslverr,
	aesJobIf.bank job
);

	logic access;
	logic wrAccess;
	apbAddrT keyOff;
	apbAddrT plainOff;
	apbAddrT cipherOff;
	logic ctrlHit;
	logic keyHit;
	logic plainHit;
	logic cipherHit;
	logic goReq;
	logic goAccept;
	aesBlockT keyReg;
	aesBlockT plainReg;
	aesBlockT cipherReg;
	logic startReg;
	logic busy;
	logic done;

	assign access = psel & penable;
	assign wrAccess = access & pwrite;

	// Word offsets into each four-word group
	assign keyOff = paddr - RegKey0;
	assign plainOff = paddr - RegPlain0;
	assign cipherOff = paddr - RegCipher0;

	assign ctrlHit = (paddr == RegCtrl);
	assign keyHit = (keyOff < 8'd16) && (keyOff[1:0] == 2'b00);
	assign plainHit = (plainOff < 8'd16) && (plainOff[1:0] == 2'b00);
	assign cipherHit = (cipherOff < 8'd16) && (cipherOff[1:0] == 2'b00);

	assign goReq = wrAccess & ctrlHit & pwdata[CtrlGoBit];
	assign goAccept = goReq & ~busy;

	// Zero wait states
	assign pready = 1'b1;

	assign pslverr = access & (~(ctrlHit | keyHit | plainHit | cipherHit)
		| (pwrite & cipherHit)
		| (goReq & busy));

	always_comb begin
		prdata = UnmappedRead;
		if (ctrlHit) begin
			prdata = '0;
			prdata[CtrlDoneBit] = done;
			prdata[CtrlGoBit] = busy;
		end else if (keyHit) begin
			prdata = keyReg[keyOff[3:2]];
		end else if (plainHit) begin
			prdata = plainReg[plainOff[3:2]];
		end else if (cipherHit) begin
			prdata = cipherReg[cipherOff[3:2]];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keyReg <= '0;
			plainReg <= '0;
			cipherReg <= '0;
			startReg <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			startReg <= goAccept;
			if (wrAccess && keyHit) begin
				keyReg[keyOff[3:2]] <= pwdata;
			end
			if (wrAccess && plainHit) begin
				plainReg[plainOff[3:2]] <= pwdata;
			end
			// A busy GO is dropped and only flagged on pslverr
			if (goAccept) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (job.resultValid) begin
				busy <= 1'b0;
				done <= 1'b1;
				cipherReg <= job.cipherBlock;
			end
		end
	end

	assign job.start = startReg;
	assign job.key = keyReg;
	assign job.plainBlock = plainReg;

endmodule

`default_nettype wire

//--- hw/aesKeySchedule.sv
`default_nettype none

module aesKeySchedule
	import aesPkg::*;
(
	input logic clk,
	input logic rst_n,
	aesJobIf.sched job,
	aesRoundKeyIf.sched rk
);

	logic running;
	logic keyValid;
	roundIdxT idxReg;
	roundIdxT curIdx;
	aesBlockT rkReg;
	aesBlockT curKey;
	aesBlockT nextKey;
	aesWordT temp;
	logic [7:0] rcon;

	// Round 0 is the cipher key itself, presented in the start cycle
	assign keyValid = job.start | running;
	assign curIdx = job.start ? '0 : idxReg;
	assign curKey = job.start ? job.key : rkReg;

	always_comb begin
		temp = subWord(rotWord(curKey[3])) ^ {rcon, 24'h000000};
		nextKey[0] = curKey[0] ^ temp;
		nextKey[1] = curKey[1] ^ nextKey[0];
		nextKey[2] = curKey[2] ^ nextKey[1];
		nextKey[3] = curKey[3] ^ nextKey[2];
	end

	// rcon idles at 1 so the first expansion needs no extra cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			idxReg <= '0;
			rcon <= 8'h01;
		end else if (keyValid) begin
			if (curIdx == NumRounds) begin
				running <= 1'b0;
				idxReg <= '0;
				rcon <= 8'h01;
			end else begin
				running <= 1'b1;
				idxReg <= curIdx + 4'd1;
				rcon <= nextRcon(rcon);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (keyValid) begin
			rkReg <= nextKey;
		end
	end

	assign rk.keyValid = keyValid;
	assign rk.roundIdx = curIdx;
	assign rk.roundKey = curKey;
	assign rk.plainBlock = job.plainBlock;

endmodule

`default_nettype wire

//--- hw/aesRoundCore.sv
`default_nettype none

module aesRoundCore
	import aesPkg::*;
(
	input logic clk,
	input logic rst_n,
	aesRoundKeyIf.core rk,
	aesJobIf.core job
);

	aesBlockT state;
	aesBlockT shifted;
	aesBlockT roundOut;
	logic resultValidReg;

	always_comb begin
		shifted = subShiftRows(state);
		if (rk.roundIdx == '0) begin
			// Initial AddRoundKey
			roundOut = rk.plainBlock ^ rk.roundKey;
		end else if (rk.roundIdx == NumRounds) begin
			// Final round has no MixColumns
			roundOut = shifted ^ rk.roundKey;
		end else begin
			roundOut = mixColumns(shifted) ^ rk.roundKey;
		end
	end

	// Each presented key is consumed in its own cycle
	always_ff @(posedge clk) begin
		if (rk.keyValid) begin
			state <= roundOut;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resultValidReg <= 1'b0;
		end else begin
			resultValidReg <= rk.keyValid && (rk.roundIdx == NumRounds);
		end
	end

	assign job.resultValid = resultValidReg;
	assign job.cipherBlock = state;

endmodule

`default_nettype wire

//--- hw/aesAccel.sv
`default_nettype none

module aesAccel
	import aesPkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input aesWordT pwdata,
	output aesWordT prdata,
	output logic pready,
	output logic pslverr
);

	aesJobIf job ();
	aesRoundKeyIf rk ();

	// APB slave and job launch
	aesRegBank i_regBank (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.job(job.bank)
	);

	aesKeySchedule i_keySchedule (
		.clk(clk),
		.rst_n(rst_n),
		.job(job.sched),
		.rk(rk.sched)
	);

	// One round per clock
	aesRoundCore i_roundCore (
		.clk(clk),
		.rst_n(rst_n),
		.rk(rk.core),
		.job(job.core)
	);

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`default_nettype none

module tbClock #(
	parameter int PeriodNs = 100,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever begin
			#(PeriodNs / 2) clk = ~clk;
		end
	end

	// Released on a falling edge, clear of the rising one
	initial begin
		rst_n = 1'b0;
		#(PeriodNs * ResetCycles);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/tbAesAccel.sv
`default_nettype none

module tbAesAccel
	import aesPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod = 100;
	localparam int DriveDelay = 10;
	localparam int NumRandomJobs = 32;
	// Watchdog budget in clock cycles
	localparam int JobBudget = 40;
	localparam int CyclesPerJob = 40;
	localparam int MarginCycles = 500;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddrT paddr;
	aesWordT pwdata;
	aesWordT prdata;
	logic pready;
	logic pslverr;

	integer seed;
	logic [7:0] refSbox [256];
	apbAddrT unmappedAddrs [4] = '{8'h04, 8'h0a, 8'h38, 8'hff};

	tbClock #(.PeriodNs(ClkPeriod), .ResetCycles(3)) i_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	aesAccel i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	task automatic failAndStop();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic compareWord(input aesWordT got, input aesWordT exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			failAndStop();
		end
	endtask

	task automatic compareBlock(input aesBlockT got, input aesBlockT exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			failAndStop();
		end
	endtask

	task automatic compareBit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
			failAndStop();
		end
	endtask

	// GF(2^8) arithmetic for the reference model
	function automatic logic [7:0] timesTwo(logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gfMul(logic [7:0] a, logic [7:0] b);
		logic [7:0] p;
		p = 8'h00;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				p = p ^ a;
			end
			a = timesTwo(a);
		end
		return p;
	endfunction

	function automatic logic [7:0] rotl8(logic [7:0] b, int n);
		return (b << n) | (b >> (8 - n));
	endfunction

	// S-box from the field inverse and the affine map
	task automatic buildSbox();
		logic [7:0] inv;
		for (int x = 0; x < 256; x++) begin
			inv = 8'h00;
			for (int y = 1; y < 256; y++) begin
				if (gfMul(8'(x), 8'(y)) == 8'h01) begin
					inv = 8'(y);
				end
			end
			refSbox[x] = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4)
				^ 8'h63;
		end
	endtask

	function automatic aesBlockT modelEncrypt(aesBlockT key, aesBlockT pt);
		logic [7:0] st [16];
		logic [7:0] tmp [16];
		aesWordT w [44];
		aesWordT t;
		logic [7:0] rc;
		logic [7:0] a0, a1, a2, a3;
		aesBlockT ct;
		rc = 8'h01;
		for (int i = 0; i < 4; i++) begin
			w[i] = key[i];
		end
		for (int i = 4; i < 44; i++) begin
			t = w[i - 1];
			if (i % 4 == 0) begin
				t = {t[23:0], t[31:24]};
				t = {refSbox[t[31:24]], refSbox[t[23:16]], refSbox[t[15:8]], refSbox[t[7:0]]};
				t = t ^ {rc, 24'h000000};
				rc = timesTwo(rc);
			end
			w[i] = w[i - 4] ^ t;
		end
		// Byte i sits in column i/4, row i%4
		for (int i = 0; i < 16; i++) begin
			st[i] = pt[i / 4][31 - 8 * (i % 4) -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
		end
		for (int r = 1; r <= 10; r++) begin
			for (int i = 0; i < 16; i++) begin
				tmp[i] = refSbox[st[((i / 4 + i % 4) % 4) * 4 + i % 4]];
			end
			for (int c = 0; c < 4; c++) begin
				a0 = tmp[4 * c];
				a1 = tmp[4 * c + 1];
				a2 = tmp[4 * c + 2];
				a3 = tmp[4 * c + 3];
				if (r == 10) begin
					st[4 * c] = a0;
					st[4 * c + 1] = a1;
					st[4 * c + 2] = a2;
					st[4 * c + 3] = a3;
				end else begin
					st[4 * c] = gfMul(a0, 8'h02) ^ gfMul(a1, 8'h03) ^ a2 ^ a3;
					st[4 * c + 1] = a0 ^ gfMul(a1, 8'h02) ^ gfMul(a2, 8'h03) ^ a3;
					st[4 * c + 2] = a0 ^ a1 ^ gfMul(a2, 8'h02) ^ gfMul(a3, 8'h03);
					st[4 * c + 3] = gfMul(a0, 8'h03) ^ a1 ^ a2 ^ gfMul(a3, 8'h02);
				end
			end
			for (int i = 0; i < 16; i++) begin
				st[i] = st[i] ^ w[4 * r + i / 4][31 - 8 * (i % 4) -: 8];
			end
		end
		for (int i = 0; i < 16; i++) begin
			ct[i / 4][31 - 8 * (i % 4) -: 8] = st[i];
		end
		return ct;
	endfunction

	// Each transfer starts its setup phase in the current cycle
	task automatic apbWrite(input apbAddrT addr, input aesWordT data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#DriveDelay;
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;
		compareBit(pready, 1'b1, "pready on write");
		@(posedge clk);
		#DriveDelay;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbRead(input apbAddrT addr, output aesWordT data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#DriveDelay;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		compareBit(pready, 1'b1, "pready on read");
		@(posedge clk);
		#DriveDelay;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
		#DriveDelay;
	endtask

	task automatic randomBlock(output aesBlockT b);
		for (int i = 0; i < 4; i++) begin
			b[i] = $random(seed);
		end
	endtask

	task automatic loadJob(input aesBlockT key, input aesBlockT plain);
		logic err;
		for (int i = 0; i < 4; i++) begin
			apbWrite(RegKey0 + apbAddrT'(4 * i), key[i], err);
			compareBit(err, 1'b0, "pslverr on key write");
			apbWrite(RegPlain0 + apbAddrT'(4 * i), plain[i], err);
			compareBit(err, 1'b0, "pslverr on plaintext write");
		end
	endtask

	task automatic startJob();
		logic err;
		apbWrite(RegCtrl, 32'h1 << CtrlGoBit, err);
		compareBit(err, 1'b0, "pslverr on GO while idle");
	endtask

	// Polls the status word until done is set
	task automatic waitDone();
		aesWordT data;
		logic err;
		data = '0;
		while (data[CtrlDoneBit] !== 1'b1) begin
			apbRead(RegCtrl, data, err);
			compareBit(err, 1'b0, "pslverr on status poll");
		end
	endtask

	task automatic readCipher(output aesBlockT ct);
		logic err;
		for (int i = 0; i < 4; i++) begin
			apbRead(RegCipher0 + apbAddrT'(4 * i), ct[i], err);
			compareBit(err, 1'b0, "pslverr on ciphertext read");
		end
	endtask

	task automatic checkJob(input aesBlockT key, input aesBlockT plain, input string what);
		aesBlockT ct;
		loadJob(key, plain);
		startJob();
		waitDone();
		readCipher(ct);
		compareBlock(ct, modelEncrypt(key, plain), what);
	endtask

	initial begin
		#(ClkPeriod * (JobBudget * CyclesPerJob + MarginCycles));
		$display("Watchdog expired at %0t ns, the run hung", $time);
		failAndStop();
	end

	initial begin
		aesBlockT katKey;
		aesBlockT katPlain;
		aesBlockT katCipher;
		aesBlockT key;
		aesBlockT plain;
		aesBlockT ct;
		aesWordT data;
		aesWordT expWord;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'h7aaf;
		katKey = 128'h000102030405060708090a0b0c0d0e0f;
		katPlain = 128'h00112233445566778899aabbccddeeff;
		katCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		buildSbox();
		compareBlock(modelEncrypt(katKey, katPlain), katCipher, "reference model known answer");
		wait (rst_n === 1'b1);
		@(posedge clk);
		#DriveDelay;

		// Every mapped register is zero after reset
		apbRead(RegCtrl, data, err);
		compareWord(data, 32'h0, "status after reset");
		compareBit(err, 1'b0, "pslverr on status after reset");
		for (int i = 0; i < 12; i++) begin
			apbRead(RegKey0 + apbAddrT'(4 * i), data, err);
			compareWord(data, 32'h0, "data register after reset");
			compareBit(err, 1'b0, "pslverr on data register after reset");
		end

		for (int i = 0; i < 4; i++) begin
			apbRead(unmappedAddrs[i], data, err);
			compareWord(data, UnmappedRead, "unmapped read data");
			compareBit(err, 1'b1, "pslverr on unmapped read");
		end

		// FIPS-197 known answer with register readback
		loadJob(katKey, katPlain);
		for (int i = 0; i < 4; i++) begin
			apbRead(RegKey0 + apbAddrT'(4 * i), data, err);
			compareWord(data, katKey[i], "key readback");
			apbRead(RegPlain0 + apbAddrT'(4 * i), data, err);
			compareWord(data, katPlain[i], "plaintext readback");
		end
		startJob();
		waitDone();
		readCipher(ct);
		compareBlock(ct, katCipher, "known answer ciphertext");

		// Ciphertext is read only
		apbWrite(RegCipher0, 32'hdeadbeef, err);
		compareBit(err, 1'b1, "pslverr on ciphertext write");
		apbRead(RegCipher0, data, err);
		compareWord(data, katCipher[0], "ciphertext after write attempt");

		for (int j = 0; j < NumRandomJobs; j++) begin
			randomBlock(key);
			randomBlock(plain);
			checkJob(key, plain, "random job ciphertext");
		end

		// Second GO while the first job runs
		randomBlock(key);
		randomBlock(plain);
		loadJob(key, plain);
		startJob();
		apbWrite(RegCtrl, 32'h1 << CtrlGoBit, err);
		compareBit(err, 1'b1, "pslverr on GO while busy");
		waitDone();
		readCipher(ct);
		compareBlock(ct, modelEncrypt(key, plain), "ciphertext after rejected GO");

		// Status two and thirteen cycles after the GO access phase
		randomBlock(key);
		randomBlock(plain);
		loadJob(key, plain);
		startJob();
		apbRead(RegCtrl, data, err);
		expWord = '0;
		expWord[CtrlGoBit] = 1'b1;
		compareWord(data, expWord, "status two cycles after GO");
		idleCycles(9);
		apbRead(RegCtrl, data, err);
		expWord = '0;
		expWord[CtrlDoneBit] = 1'b1;
		compareWord(data, expWord, "status thirteen cycles after GO");
		readCipher(ct);
		compareBlock(ct, modelEncrypt(key, plain), "timed job ciphertext");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/aesPkg.sv
hw/aesJobIf.sv
hw/aesRoundKeyIf.sv
hw/aesRegBank.sv
hw/aesKeySchedule.sv
hw/aesRoundCore.sv
hw/aesAccel.sv
testbench/tbClock.sv
testbench/tbAesAccel.sv

//--- Bender.yml
package:
  name: aes_accel

sources:
  # Design, in compile order
  - files:
      - hw/aesPkg.sv
      - hw/aesJobIf.sv
      - hw/aesRoundKeyIf.sv
      - hw/aesRegBank.sv
      - hw/aesKeySchedule.sv
      - hw/aesRoundCore.sv
      - hw/aesAccel.sv

  # Testbench, top module tbAesAccel
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbAesAccel.sv
